//--- tsc_cpu.f
+incdir+.
tsc_pkg.sv
tsc_fetch.sv
tsc_decoder.sv
tsc_regfile.sv
tsc_alu.sv
tsc_core.sv
tsc_tb.sv

//--- Makefile
TOP = tsc_tb

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tsc_cpu.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

lint:
	verilator --lint-only --timing --assert --top-module tsc_core -f tsc_cpu.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- tsc_tb_ref.svh
`ifndef TSC_TB_REF_SVH
`define TSC_TB_REF_SVH

//////////////////////////////
// instruction encoders
//////////////////////////////
function automatic word_t enc_r(func_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
   return {OP_RTYPE, rs, rt, rd, fn};
endfunction

function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [7:0] imm);
   return {op, rs, rt, imm};
endfunction

function automatic word_t enc_j(opcode_t op, logic [11:0] target);
   return {op, target};
endfunction

// fibonacci lfsr, taps 32 22 2 1
logic [31:0] lfsr = 32'h70b24188;

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(int n);
   logic [31:0] v;
   logic        fb;
   v = '0;
   for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
   end
   return v;
endfunction

// unused words are HLT, operand bits follow the address
function automatic void fill_memory();
   logic [7:0] ad;
   for (int a = 0; a < 256; a++) begin
      ad     = 8'(a);
      mem[a] = {OP_RTYPE, ad[7:2] ^ {ad[1:0], 4'b0000}, FN_HLT};
   end
endfunction

//////////////////////////////
// reference ISA model
//////////////////////////////
function automatic void run_reference();
   word_t    regs [`TSC_NUM_REGS];
   word_t    pc;
   word_t    ir;
   word_t    next;
   word_t    a;
   word_t    b;
   word_t    simm;
   opcode_t  op;
   func_t    fn;
   reg_idx_t rs;
   reg_idx_t rt;
   reg_idx_t rd;
   logic     done;
   int       steps;
   exp_out.delete();
   exp_count = '0;
   for (int r = 0; r < `TSC_NUM_REGS; r++) begin
      regs[r] = '0;
   end
   pc    = `TSC_RESET_PC;
   done  = 1'b0;
   steps = 0;
   while (!done && steps < 1000) begin
      ir   = mem[pc[7:0]];
      op   = ir[15:12];
      fn   = ir[5:0];
      rs   = ir[11:10];
      rt   = ir[9:8];
      rd   = ir[7:6];
      a    = regs[rs];
      b    = regs[rt];
      simm = {{8{ir[7]}}, ir[7:0]};
      next = pc + 16'd1;
      // every executed instruction commits, HLT too
      exp_count = exp_count + 16'd1;
      steps++;
      case (op)
         OP_BNE: if (a != b) next = pc + 16'd1 + simm;
         OP_BEQ: if (a == b) next = pc + 16'd1 + simm;
         OP_BGZ: if ($signed(a) > 0) next = pc + 16'd1 + simm;
         OP_BLZ: if ($signed(a) < 0) next = pc + 16'd1 + simm;
         OP_ADI: regs[rt] = a + simm;
         OP_ORI: regs[rt] = a | {8'h00, ir[7:0]};
         OP_LHI: regs[rt] = {ir[7:0], 8'h00};
         // page-relative jumps
         OP_JMP: next = {pc[15:12], ir[11:0]};
         OP_JAL: begin
            regs[`TSC_LINK_REG] = pc + 16'd1;
            next = {pc[15:12], ir[11:0]};
         end
         OP_RTYPE: begin
            case (fn)
               FN_ADD: regs[rd] = a + b;
               FN_SUB: regs[rd] = a - b;
               FN_AND: regs[rd] = a & b;
               FN_ORR: regs[rd] = a | b;
               FN_NOT: regs[rd] = ~a;
               FN_TCP: regs[rd] = 16'd0 - a;
               FN_SHL: regs[rd] = {a[14:0], 1'b0};
               FN_SHR: regs[rd] = {a[15], a[15:1]};
               FN_JPR: next = a;
               // target is rs before the link write
               FN_JRL: begin
                  regs[`TSC_LINK_REG] = pc + 16'd1;
                  next = a;
               end
               FN_WWD: exp_out.push_back(a);
               FN_HLT: done = 1'b1;
               default: ;
            endcase
         end
         default: ;
      endcase
      pc = next;
   end
endfunction

//////////////////////////////
// random program, forward control flow only
//////////////////////////////
function automatic void gen_random_program();
   int      n;
   int      kind;
   int      off;
   int      tgt;
   opcode_t op;
   fill_memory();
   n = 16 + int'(rand_bits(4));
   for (int i = 0; i < n - 1; i++) begin
      kind = int'(rand_bits(3));
      case (kind)
         0, 1: mem[i] = enc_r(func_t'(rand_bits(3)), reg_idx_t'(rand_bits(2)),
                              reg_idx_t'(rand_bits(2)), reg_idx_t'(rand_bits(2)));
         2: mem[i] = enc_i(OP_ADI, reg_idx_t'(rand_bits(2)), reg_idx_t'(rand_bits(2)),
                           8'(rand_bits(8)));
         3: begin
            op     = (rand_bits(1) == 32'd1) ? OP_ORI : OP_LHI;
            mem[i] = enc_i(op, reg_idx_t'(rand_bits(2)), reg_idx_t'(rand_bits(2)),
                           8'(rand_bits(8)));
         end
         // branch lands at most on the final HLT
         5: begin
            op  = opcode_t'(rand_bits(2));
            off = int'(rand_bits(2));
            if (i + 1 + off > n - 1) off = n - 2 - i;
            mem[i] = enc_i(op, reg_idx_t'(rand_bits(2)), reg_idx_t'(rand_bits(2)), 8'(off));
         end
         6: begin
            op  = (rand_bits(1) == 32'd1) ? OP_JAL : OP_JMP;
            tgt = i + 1 + int'(rand_bits(2));
            if (tgt > n - 1) tgt = n - 1;
            mem[i] = enc_j(op, 12'(tgt));
         end
         default: mem[i] = enc_r(FN_WWD, reg_idx_t'(rand_bits(2)), 2'd0, 2'd0);
      endcase
   end
   mem[n - 1] = enc_r(FN_HLT, 2'd0, 2'd0, 2'd0);
endfunction

`endif

//--- tsc_tb.sv
`timescale 1ns/10ps
`include "tsc_defines.svh"

module tsc_tb;
   import tsc_pkg::*;

   logic  clk;
   logic  reset_n;
   word_t i_inst_data;
   word_t o_inst_addr;
   word_t o_output_port;
   logic  o_output_valid;
   logic  o_halted;
   word_t o_num_inst;

   // instruction memory and expected results
   word_t mem [256];
   word_t exp_out [$];
   word_t exp_count;
   int    prog_len;

   // watchdog state
   logic  running;
   int    cycles;
   int    budget;

   `include "tsc_tb_ref.svh"

   tsc_core tsc_core_inst (
      .clk            (clk),
      .reset_n        (reset_n),
      .i_inst_data    (i_inst_data),
      .o_inst_addr    (o_inst_addr),
      .o_output_port  (o_output_port),
      .o_output_valid (o_output_valid),
      .o_halted       (o_halted),
      .o_num_inst     (o_num_inst)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // memory answers shortly after each edge
   always @(posedge clk) begin
      #1;
      i_inst_data <= mem[o_inst_addr[7:0]];
   end

   //////////////////////////////
   // checks
   //////////////////////////////
   task automatic fail_run(string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_output(word_t got, word_t exp);
      if (got !== exp) begin
         fail_run($sformatf("FAILED time=%0t o_output_port got %h expected %h",
                            $time, got, exp));
      end
   endtask

   task automatic check_count(word_t got, word_t exp);
      if (got !== exp) begin
         fail_run($sformatf("FAILED time=%0t o_num_inst got %h expected %h",
                            $time, got, exp));
      end
   endtask

   task automatic check_addr(word_t got, word_t exp);
      if (got !== exp) begin
         fail_run($sformatf("FAILED time=%0t o_inst_addr got %h expected %h",
                            $time, got, exp));
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         fail_run($sformatf("FAILED time=%0t %s got %b expected %b",
                            $time, name, got, exp));
      end
   endtask

   // each strobe takes the next expected value
   always @(negedge clk) begin
      if (reset_n && o_output_valid) begin
         if (exp_out.size() == 0) begin
            fail_run("output strobe with no value left to expect");
         end else begin
            check_output(o_output_port, exp_out.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      if (running) begin
         cycles = cycles + 1;
         if (cycles > budget) begin
            fail_run("timeout, core never halted");
         end
      end
   end

   //////////////////////////////
   // directed programs
   //////////////////////////////
   task automatic emit(word_t w);
      mem[prog_len] = w;
      prog_len++;
   endtask

   // back-to-back reuse of destinations
   task automatic build_alu_program();
      fill_memory();
      prog_len = 0;
      emit(enc_i(OP_LHI, 2'd0, 2'd1, 8'h12));
      emit(enc_i(OP_ORI, 2'd1, 2'd1, 8'h34));
      emit(enc_i(OP_ADI, 2'd1, 2'd1, 8'hff));
      emit(enc_r(FN_WWD, 2'd1, 2'd0, 2'd0));
      emit(enc_r(FN_ADD, 2'd1, 2'd1, 2'd2));
      emit(enc_r(FN_SUB, 2'd2, 2'd1, 2'd3));
      emit(enc_r(FN_WWD, 2'd3, 2'd0, 2'd0));
      emit(enc_r(FN_AND, 2'd3, 2'd2, 2'd0));
      emit(enc_r(FN_WWD, 2'd0, 2'd0, 2'd0));
      emit(enc_r(FN_NOT, 2'd0, 2'd0, 2'd0));
      emit(enc_r(FN_TCP, 2'd0, 2'd0, 2'd1));
      emit(enc_r(FN_SHL, 2'd1, 2'd0, 2'd2));
      emit(enc_r(FN_SHR, 2'd2, 2'd0, 2'd3));
      emit(enc_r(FN_WWD, 2'd2, 2'd0, 2'd0));
      emit(enc_r(FN_WWD, 2'd3, 2'd0, 2'd0));
      emit(enc_r(FN_ORR, 2'd1, 2'd3, 2'd0));
      emit(enc_r(FN_WWD, 2'd0, 2'd0, 2'd0));
      emit(enc_r(FN_HLT, 2'd0, 2'd0, 2'd0));
   endtask

   // taken branch skips the increment of r1
   task automatic emit_branch_case(opcode_t op, reg_idx_t rs, reg_idx_t rt);
      emit(enc_i(op, rs, rt, 8'd1));
      emit(enc_i(OP_ADI, 2'd1, 2'd1, 8'd1));
      emit(enc_r(FN_WWD, 2'd1, 2'd0, 2'd0));
   endtask

   task automatic build_branch_program();
      fill_memory();
      prog_len = 0;
      emit(enc_i(OP_ADI, 2'd0, 2'd1, 8'd5));
      emit(enc_i(OP_ADI, 2'd0, 2'd2, 8'hfd));
      emit_branch_case(OP_BNE, 2'd1, 2'd1);
      emit_branch_case(OP_BNE, 2'd1, 2'd2);
      emit_branch_case(OP_BEQ, 2'd1, 2'd2);
      emit_branch_case(OP_BEQ, 2'd3, 2'd0);
      emit_branch_case(OP_BGZ, 2'd1, 2'd0);
      emit_branch_case(OP_BGZ, 2'd2, 2'd0);
      emit_branch_case(OP_BLZ, 2'd2, 2'd0);
      emit_branch_case(OP_BLZ, 2'd3, 2'd0);
      emit(enc_r(FN_HLT, 2'd0, 2'd0, 2'd0));
   endtask

   // jal 1->3, jpr 5->7, jmp 9->11, jrl 13->15
   task automatic build_jump_program();
      fill_memory();
      prog_len = 0;
      emit(enc_i(OP_ADI, 2'd0, 2'd1, 8'h11));
      emit(enc_j(OP_JAL, 12'd3));
      emit(enc_r(FN_WWD, 2'd1, 2'd0, 2'd0));
      emit(enc_r(FN_WWD, 2'd2, 2'd0, 2'd0));
      emit(enc_i(OP_ADI, 2'd0, 2'd3, 8'd7));
      emit(enc_r(FN_JPR, 2'd3, 2'd0, 2'd0));
      emit(enc_r(FN_WWD, 2'd1, 2'd0, 2'd0));
      emit(enc_i(OP_ADI, 2'd0, 2'd0, 8'h2a));
      emit(enc_r(FN_WWD, 2'd0, 2'd0, 2'd0));
      emit(enc_j(OP_JMP, 12'd11));
      emit(enc_r(FN_WWD, 2'd1, 2'd0, 2'd0));
      emit(enc_i(OP_LHI, 2'd0, 2'd3, 8'h00));
      emit(enc_i(OP_ADI, 2'd3, 2'd3, 8'd15));
      emit(enc_r(FN_JRL, 2'd3, 2'd0, 2'd0));
      emit(enc_r(FN_WWD, 2'd1, 2'd0, 2'd0));
      emit(enc_r(FN_WWD, 2'd2, 2'd0, 2'd0));
      emit(enc_r(FN_HLT, 2'd0, 2'd0, 2'd0));
   endtask

   //////////////////////////////
   // one program from reset to halt
   //////////////////////////////
   task automatic run_program();
      run_reference();
      budget = int'(exp_count) * 4 + 60;
      @(posedge clk);
      #1;
      reset_n = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      reset_n = 1'b1;
      // state before the first fetch completes
      @(negedge clk);
      check_bit("o_halted", o_halted, 1'b0);
      check_bit("o_output_valid", o_output_valid, 1'b0);
      check_count(o_num_inst, 16'd0);
      check_addr(o_inst_addr, `TSC_RESET_PC);
      check_output(o_output_port, 16'd0);
      cycles  = 0;
      running = 1'b1;
      while (o_halted !== 1'b1) @(negedge clk);
      // a few more cycles where a late strobe would show
      repeat (4) @(negedge clk);
      running = 1'b0;
      if (exp_out.size() != 0) begin
         fail_run($sformatf("%0d expected outputs never appeared", exp_out.size()));
      end
      check_count(o_num_inst, exp_count);
   endtask

   initial begin
      reset_n     = 1'b0;
      i_inst_data = '0;
      running     = 1'b0;
      cycles      = 0;
      budget      = 0;
      prog_len    = 0;
      build_alu_program();
      run_program();
      build_branch_program();
      run_program();
      build_jump_program();
      run_program();
      for (int p = 0; p < 20; p++) begin
         gen_random_program();
         run_program();
      end
      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- tsc_core.sv
`timescale 1ns/10ps

module tsc_core (
   input  logic            clk,
   input  logic            reset_n,
   input  tsc_pkg::word_t  i_inst_data,
   output tsc_pkg::word_t  o_inst_addr,
   output tsc_pkg::word_t  o_output_port,
   output logic            o_output_valid,
   output logic            o_halted,
   output tsc_pkg::word_t  o_num_inst
);
   import tsc_pkg::*;

   // IF/ID
   word_t    ir;
   word_t    pc_id;
   logic     id_valid;

   // decode outputs
   reg_idx_t dec_rs;
   reg_idx_t dec_rt;
   reg_idx_t dec_wr_idx;
   logic     dec_reg_write;
   alu_op_t  dec_alu_op;
   logic     dec_use_imm;
   word_t    dec_imm;
   wb_src_t  dec_wb_src;
   logic     dec_is_branch;
   logic     dec_is_jump;
   logic     dec_jump_reg;
   word_t    dec_jump_imm;
   logic     dec_output_write;
   logic     dec_halt;
   word_t    rf_rs_data;
   word_t    rf_rt_data;

   // ID/EX
   logic     ex_valid;
   logic     ex_reg_write;
   logic     ex_is_branch;
   logic     ex_is_jump;
   logic     ex_jump_reg;
   logic     ex_output_write;
   logic     ex_halt;
   word_t    ex_pc;
   reg_idx_t ex_rs;
   reg_idx_t ex_rt;
   reg_idx_t ex_wr_idx;
   word_t    ex_rs_data;
   word_t    ex_rt_data;
   alu_op_t  ex_alu_op;
   logic     ex_use_imm;
   word_t    ex_imm;
   wb_src_t  ex_wb_src;
   word_t    ex_jump_imm;

   // EX stage
   word_t    fwd_a;
   word_t    fwd_b;
   word_t    alu_b;
   word_t    alu_result;
   logic     alu_taken;
   word_t    link_pc;
   word_t    jump_pc;
   word_t    ex_wb_data;
   logic     redirect;
   word_t    redirect_pc;

   // EX/WB
   logic     wb_valid;
   logic     wb_reg_write;
   logic     wb_output_write;
   logic     wb_halt;
   reg_idx_t wb_idx;
   word_t    wb_data;
   logic     rf_we;

   // pipeline control
   logic     hold;
   logic     freeze;
   logic     halted_r;
   word_t    num_inst;

   tsc_fetch tsc_fetch_inst (
      .clk           (clk),
      .reset_n       (reset_n),
      .i_inst_data   (i_inst_data),
      .i_redirect    (redirect),
      .i_redirect_pc (redirect_pc),
      .i_hold        (hold),
      .i_halted      (freeze),
      .o_inst_addr   (o_inst_addr),
      .o_ir          (ir),
      .o_pc_id       (pc_id)
   );

   tsc_decoder tsc_decoder_inst (
      .i_ir           (ir),
      .o_rs           (dec_rs),
      .o_rt           (dec_rt),
      .o_wr_idx       (dec_wr_idx),
      .o_reg_write    (dec_reg_write),
      .o_alu_op       (dec_alu_op),
      .o_use_imm      (dec_use_imm),
      .o_imm          (dec_imm),
      .o_wb_src       (dec_wb_src),
      .o_is_branch    (dec_is_branch),
      .o_is_jump      (dec_is_jump),
      .o_jump_reg     (dec_jump_reg),
      .o_jump_imm     (dec_jump_imm),
      .o_output_write (dec_output_write),
      .o_halt         (dec_halt)
   );

   tsc_regfile tsc_regfile_inst (
      .clk       (clk),
      .reset_n   (reset_n),
      .i_rs      (dec_rs),
      .i_rt      (dec_rt),
      .i_we      (rf_we),
      .i_wr_idx  (wb_idx),
      .i_wr_data (wb_data),
      .o_rs_data (rf_rs_data),
      .o_rt_data (rf_rt_data)
   );

   tsc_alu tsc_alu_inst (
      .i_op     (ex_alu_op),
      .i_a      (fwd_a),
      .i_b      (alu_b),
      .o_result (alu_result),
      .o_taken  (alu_taken)
   );

   // HLT in ID parks fetch, HLT in WB stops everything
   assign hold   = id_valid & dec_halt;
   assign freeze = halted_r | (wb_valid & wb_halt);

   //////////////////////////////
   // IF/ID valid
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         id_valid <= 1'b0;
      end else if (!freeze) begin
         if (redirect) begin
            id_valid <= 1'b0;
         end else if (!hold) begin
            id_valid <= 1'b1;
         end
      end
   end

   //////////////////////////////
   // ID/EX latch
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ex_valid        <= 1'b0;
         ex_reg_write    <= 1'b0;
         ex_is_branch    <= 1'b0;
         ex_is_jump      <= 1'b0;
         ex_jump_reg     <= 1'b0;
         ex_output_write <= 1'b0;
         ex_halt         <= 1'b0;
      end else if (!freeze) begin
         // redirect in EX squashes the instruction behind it
         ex_valid        <= id_valid & ~redirect;
         ex_reg_write    <= dec_reg_write;
         ex_is_branch    <= dec_is_branch;
         ex_is_jump      <= dec_is_jump;
         ex_jump_reg     <= dec_jump_reg;
         ex_output_write <= dec_output_write;
         ex_halt         <= dec_halt;
      end
   end

   always_ff @(posedge clk) begin
      if (!freeze) begin
         ex_pc       <= pc_id;
         ex_rs       <= dec_rs;
         ex_rt       <= dec_rt;
         ex_wr_idx   <= dec_wr_idx;
         ex_rs_data  <= rf_rs_data;
         ex_rt_data  <= rf_rt_data;
         ex_alu_op   <= dec_alu_op;
         ex_use_imm  <= dec_use_imm;
         ex_imm      <= dec_imm;
         ex_wb_src   <= dec_wb_src;
         ex_jump_imm <= dec_jump_imm;
      end
   end

   //////////////////////////////
   // execute
   //////////////////////////////
   // WB result bypasses the value read in ID
   assign rf_we = wb_valid & wb_reg_write;
   assign fwd_a = (rf_we && (wb_idx == ex_rs)) ? wb_data : ex_rs_data;
   assign fwd_b = (rf_we && (wb_idx == ex_rt)) ? wb_data : ex_rt_data;
   assign alu_b = ex_use_imm ? ex_imm : fwd_b;

   assign link_pc = ex_pc + 1'b1;

   // JPR/JRL go to rs, JMP/JAL stay in the current 4K page
   assign jump_pc = ex_jump_reg ? fwd_a : {ex_pc[15:12], ex_jump_imm[11:0]};

   // taken branch is pc+1+offset, otherwise a jump
   assign redirect_pc = ex_is_jump ? jump_pc : (link_pc + ex_imm);
   assign redirect    = ex_valid & ~freeze & (ex_is_jump | (ex_is_branch & alu_taken));

   always_comb begin
      case (ex_wb_src)
         WB_IMM:  ex_wb_data = ex_imm;
         WB_LINK: ex_wb_data = link_pc;
         default: ex_wb_data = alu_result;
      endcase
   end

   //////////////////////////////
   // EX/WB latch
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wb_valid        <= 1'b0;
         wb_reg_write    <= 1'b0;
         wb_output_write <= 1'b0;
         wb_halt         <= 1'b0;
      end else if (!freeze) begin
         wb_valid        <= ex_valid;
         wb_reg_write    <= ex_reg_write;
         wb_output_write <= ex_output_write;
         wb_halt         <= ex_halt;
      end
   end

   always_ff @(posedge clk) begin
      if (!freeze) begin
         wb_idx  <= ex_wr_idx;
         wb_data <= ex_wb_data;
      end
   end

   //////////////////////////////
   // commit
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         halted_r      <= 1'b0;
         num_inst      <= '0;
         o_output_port <= '0;
      end else begin
         // one count per instruction leaving WB, HLT counted once
         if (wb_valid && !halted_r) begin
            num_inst <= num_inst + 1'b1;
         end
         if (wb_valid && wb_halt) begin
            halted_r <= 1'b1;
         end
         // WWD value shows while it sits in WB
         if (!freeze && ex_valid && ex_output_write) begin
            o_output_port <= fwd_a;
         end
      end
   end

   assign o_output_valid = wb_valid & wb_output_write;
   assign o_halted       = freeze;
   assign o_num_inst     = num_inst;

   // both slots squashed by a redirect reach WB as bubbles
   a_no_bubble_write : assert property (
      @(posedge clk) disable iff (!reset_n)
      ($past(redirect, 2) || $past(redirect, 3)) |-> (!rf_we && !o_output_valid));

   // no output strobe right out of reset
   a_no_strobe_in_reset : assert property (
      @(posedge clk) !reset_n |=> !o_output_valid);

endmodule

//--- tsc_alu.sv
`timescale 1ns/10ps

module tsc_alu (
   input  tsc_pkg::alu_op_t  i_op,
   input  tsc_pkg::word_t    i_a,
   input  tsc_pkg::word_t    i_b,
   output tsc_pkg::word_t    o_result,
   output logic              o_taken
);
   import tsc_pkg::*;

   always_comb begin
      o_result = '0;
      o_taken  = 1'b0;
      case (i_op)
         //////////////////////////////
         // arithmetic and logic
         //////////////////////////////
         ALU_ADD: o_result = i_a + i_b;
         ALU_SUB: o_result = i_a - i_b;
         ALU_AND: o_result = i_a & i_b;
         ALU_ORR: o_result = i_a | i_b;
         // unary ops ignore i_b
         ALU_NOT: o_result = ~i_a;
         ALU_TCP: o_result = ~i_a + 1'b1;
         ALU_SHL: o_result = i_a << 1;
         // arithmetic, keeps the sign bit
         ALU_SHR: o_result = $signed(i_a) >>> 1;

         //////////////////////////////
         // branch compares
         //////////////////////////////
         ALU_BNE: o_taken = (i_a != i_b);
         ALU_BEQ: o_taken = (i_a == i_b);
         // signed tests against zero, rt unused
         ALU_BGZ: o_taken = ($signed(i_a) > 0);
         ALU_BLZ: o_taken = ($signed(i_a) < 0);
         default: ;
      endcase
   end

endmodule

//--- tsc_regfile.sv
`timescale 1ns/10ps
`include "tsc_defines.svh"

module tsc_regfile (
   input  logic               clk,
   input  logic               reset_n,
   input  tsc_pkg::reg_idx_t  i_rs,
   input  tsc_pkg::reg_idx_t  i_rt,
   input  logic               i_we,
   input  tsc_pkg::reg_idx_t  i_wr_idx,
   input  tsc_pkg::word_t     i_wr_data,
   output tsc_pkg::word_t     o_rs_data,
   output tsc_pkg::word_t     o_rt_data
);
   import tsc_pkg::*;

   word_t regs [`TSC_NUM_REGS];

   //////////////////////////////
   // write port, from WB
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < `TSC_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_wr_idx] <= i_wr_data;
      end
   end

   // read ports
   // same-cycle write shows through, so ID sees the WB result
   assign o_rs_data = (i_we && (i_wr_idx == i_rs)) ? i_wr_data : regs[i_rs];
   assign o_rt_data = (i_we && (i_wr_idx == i_rt)) ? i_wr_data : regs[i_rt];

endmodule

//--- tsc_decoder.sv
`timescale 1ns/10ps
`include "tsc_defines.svh"

module tsc_decoder (
   input  tsc_pkg::word_t     i_ir,
   output tsc_pkg::reg_idx_t  o_rs,
   output tsc_pkg::reg_idx_t  o_rt,
   output tsc_pkg::reg_idx_t  o_wr_idx,
   output logic               o_reg_write,
   output tsc_pkg::alu_op_t   o_alu_op,
   output logic               o_use_imm,
   output tsc_pkg::word_t     o_imm,
   output tsc_pkg::wb_src_t   o_wb_src,
   output logic               o_is_branch,
   output logic               o_is_jump,
   output logic               o_jump_reg,
   output tsc_pkg::word_t     o_jump_imm,
   output logic               o_output_write,
   output logic               o_halt
);
   import tsc_pkg::*;

   opcode_t  opcode;
   func_t    func;
   reg_idx_t rd;
   word_t    imm_sext;
   word_t    imm_zext;
   word_t    imm_high;

   // instruction fields
   assign opcode   = i_ir[15:12];
   assign func     = i_ir[5:0];
   assign o_rs     = i_ir[11:10];
   assign o_rt     = i_ir[9:8];
   assign rd       = i_ir[7:6];

   // immediate forms
   assign imm_sext = {{8{i_ir[7]}}, i_ir[7:0]};
   assign imm_zext = {8'h00, i_ir[7:0]};
   assign imm_high = {i_ir[7:0], 8'h00};

   // 12-bit page offset for JMP/JAL
   assign o_jump_imm = {4'h0, i_ir[11:0]};

   always_comb begin
      // default is a no-op; I-type writes rt
      o_wr_idx       = o_rt;
      o_reg_write    = 1'b0;
      o_alu_op       = ALU_ADD;
      o_use_imm      = 1'b0;
      o_imm          = imm_sext;
      o_wb_src       = WB_ALU;
      o_is_branch    = 1'b0;
      o_is_jump      = 1'b0;
      o_jump_reg     = 1'b0;
      o_output_write = 1'b0;
      o_halt         = 1'b0;
      case (opcode)
         // branches compare rs against rt or zero
         OP_BNE: begin
            o_is_branch = 1'b1;
            o_alu_op    = ALU_BNE;
         end
         OP_BEQ: begin
            o_is_branch = 1'b1;
            o_alu_op    = ALU_BEQ;
         end
         OP_BGZ: begin
            o_is_branch = 1'b1;
            o_alu_op    = ALU_BGZ;
         end
         OP_BLZ: begin
            o_is_branch = 1'b1;
            o_alu_op    = ALU_BLZ;
         end
         OP_ADI: begin
            o_reg_write = 1'b1;
            o_use_imm   = 1'b1;
         end
         OP_ORI: begin
            o_reg_write = 1'b1;
            o_use_imm   = 1'b1;
            o_alu_op    = ALU_ORR;
            o_imm       = imm_zext;
         end
         // LHI bypasses the alu
         OP_LHI: begin
            o_reg_write = 1'b1;
            o_imm       = imm_high;
            o_wb_src    = WB_IMM;
         end
         OP_JMP: begin
            o_is_jump = 1'b1;
         end
         OP_JAL: begin
            o_is_jump   = 1'b1;
            o_reg_write = 1'b1;
            o_wb_src    = WB_LINK;
            o_wr_idx    = reg_idx_t'(`TSC_LINK_REG);
         end
         OP_RTYPE: begin
            case (func)
               FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
                  o_reg_write = 1'b1;
                  o_wr_idx    = rd;
                  // select equals the function code here
                  o_alu_op    = {1'b0, func[2:0]};
               end
               FN_JPR: begin
                  o_is_jump  = 1'b1;
                  o_jump_reg = 1'b1;
               end
               FN_JRL: begin
                  o_is_jump   = 1'b1;
                  o_jump_reg  = 1'b1;
                  o_reg_write = 1'b1;
                  o_wb_src    = WB_LINK;
                  o_wr_idx    = reg_idx_t'(`TSC_LINK_REG);
               end
               FN_WWD: o_output_write = 1'b1;
               FN_HLT: o_halt = 1'b1;
               default: ;
            endcase
         end
         default: ;
      endcase
   end

endmodule

//--- tsc_fetch.sv
`timescale 1ns/10ps
`include "tsc_defines.svh"

module tsc_fetch (
   input  logic            clk,
   input  logic            reset_n,
   input  tsc_pkg::word_t  i_inst_data,
   input  logic            i_redirect,
   input  tsc_pkg::word_t  i_redirect_pc,
   input  logic            i_hold,
   input  logic            i_halted,
   output tsc_pkg::word_t  o_inst_addr,
   output tsc_pkg::word_t  o_ir,
   output tsc_pkg::word_t  o_pc_id
);
   import tsc_pkg::*;

   // R-type with an unused function code, decodes to nothing
   localparam word_t NOP_INST = {OP_RTYPE, 6'd0, 6'h3f};

   word_t pc;
   word_t ir;
   word_t pc_id;

   logic  advance;

   // plain sequential fetch, predicted not-taken
   assign advance = !i_halted && !i_redirect && !i_hold;

   //////////////////////////////
   // pc and IF/ID instruction
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         pc <= `TSC_RESET_PC;
         ir <= NOP_INST;
      end else if (!i_halted) begin
         if (i_redirect) begin
            // target from EX wins over hold
            pc <= i_redirect_pc;
            ir <= NOP_INST;
         end else if (!i_hold) begin
            pc <= pc + 1'b1;
            ir <= i_inst_data;
         end
      end
   end

   // pc of the instruction now in ID
   always_ff @(posedge clk) begin
      if (advance) begin
         pc_id <= pc;
      end
   end

   assign o_inst_addr = pc;
   assign o_ir        = ir;
   assign o_pc_id     = pc_id;

   // no fetch movement once halt has reached WB
   a_pc_frozen_on_halt : assert property (
      @(posedge clk) disable iff (!reset_n) i_halted |=> (pc == $past(pc)));

endmodule

//--- tsc_pkg.sv
`include "tsc_defines.svh"

package tsc_pkg;

   //////////////////////////////
   // vector types
   //////////////////////////////
   typedef logic [`TSC_WORD_W-1:0]            word_t;
   typedef logic [$clog2(`TSC_NUM_REGS)-1:0]  reg_idx_t;
   typedef logic [3:0]                        opcode_t;
   typedef logic [5:0]                        func_t;
   typedef logic [3:0]                        alu_op_t;
   typedef logic [1:0]                        wb_src_t;

   //////////////////////////////
   // opcodes, ir[15:12]
   //////////////////////////////
   localparam opcode_t OP_BNE   = 4'd0;
   localparam opcode_t OP_BEQ   = 4'd1;
   localparam opcode_t OP_BGZ   = 4'd2;
   localparam opcode_t OP_BLZ   = 4'd3;
   localparam opcode_t OP_ADI   = 4'd4;
   localparam opcode_t OP_ORI   = 4'd5;
   localparam opcode_t OP_LHI   = 4'd6;
   localparam opcode_t OP_JMP   = 4'd9;
   localparam opcode_t OP_JAL   = 4'd10;
   localparam opcode_t OP_RTYPE = 4'd15;

   // function codes, ir[5:0] of R-type
   localparam func_t FN_ADD = 6'd0;
   localparam func_t FN_SUB = 6'd1;
   localparam func_t FN_AND = 6'd2;
   localparam func_t FN_ORR = 6'd3;
   localparam func_t FN_NOT = 6'd4;
   localparam func_t FN_TCP = 6'd5;
   localparam func_t FN_SHL = 6'd6;
   localparam func_t FN_SHR = 6'd7;
   localparam func_t FN_JPR = 6'd25;
   localparam func_t FN_JRL = 6'd26;
   localparam func_t FN_WWD = 6'd28;
   localparam func_t FN_HLT = 6'd29;

   // alu selects; low eight line up with the R-type function codes
   localparam alu_op_t ALU_ADD = 4'd0;
   localparam alu_op_t ALU_SUB = 4'd1;
   localparam alu_op_t ALU_AND = 4'd2;
   localparam alu_op_t ALU_ORR = 4'd3;
   localparam alu_op_t ALU_NOT = 4'd4;
   localparam alu_op_t ALU_TCP = 4'd5;
   localparam alu_op_t ALU_SHL = 4'd6;
   localparam alu_op_t ALU_SHR = 4'd7;
   // branch compares
   localparam alu_op_t ALU_BNE = 4'd8;
   localparam alu_op_t ALU_BEQ = 4'd9;
   localparam alu_op_t ALU_BGZ = 4'd10;
   localparam alu_op_t ALU_BLZ = 4'd11;

   // writeback sources
   localparam wb_src_t WB_ALU  = 2'd0;
   localparam wb_src_t WB_IMM  = 2'd1;
   localparam wb_src_t WB_LINK = 2'd2;

endpackage

//--- tsc_defines.svh
`ifndef TSC_DEFINES_SVH
`define TSC_DEFINES_SVH

// datapath and address width
`define TSC_WORD_W 16

// general registers r0..r3
`define TSC_NUM_REGS 4

// first fetch address out of reset
`define TSC_RESET_PC 16'h0000

// link register for JAL and JRL
`define TSC_LINK_REG 2

`endif
